/* hdl/align_pkg.sv */
/*
 * Default line geometry, derived widths and the stream sideband type.
 * elems_per_line must be a power of two, at least 2.
 * Modules use these values only as parameter defaults.
 */
`default_nettype none

package align_pkg;

	// Line geometry defaults
	localparam int elem_width     = 16;
	localparam int elems_per_line = 8;
	localparam int line_width     = elem_width * elems_per_line;

	// Offset and per-line count widths
	localparam int off_width      = $clog2(elems_per_line);
	// One extra bit so a full line fits
	localparam int cnt_width      = off_width + 1;

	// Descriptor element count
	localparam int total_width    = 12;

	// Shifter pipeline depth
	localparam int shift_stages   = 2;

	// Rides with the data, never inspected
	typedef struct packed {
		logic       data_type;
		logic [2:0] elem_size;
	} sideband_t;

endpackage

`default_nettype wire

/* hdl/delay_line.sv */
/*
 * Fixed-depth shift register with a valid bit per stage.
 * DEPTH must be at least 1. Payload is not reset.
 */
`timescale 1ns/10ps
`default_nettype none

module delay_line #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = align_pkg::shift_stages
) (
	input  wire           clk,
	input  wire           rst_n,
	input  wire payload_t in_payload,
	input  wire           in_valid,
	output payload_t      out_payload,
	output logic          out_valid
);

	payload_t         pay_q [DEPTH];
	logic [DEPTH-1:0] valid_q;

	// Valid chain, cleared on reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= in_valid;
			for (int s = 1; s < DEPTH; s++) begin
				valid_q[s] <= valid_q[s-1];
			end
		end
	end

	// Payload shifts every cycle
	always_ff @(posedge clk) begin
		pay_q[0] <= in_payload;
		for (int s = 1; s < DEPTH; s++) begin
			pay_q[s] <= pay_q[s-1];
		end
	end

	assign out_payload = pay_q[DEPTH-1];
	assign out_valid   = valid_q[DEPTH-1];

endmodule

`default_nettype wire

/* hdl/line_shifter.sv */
/*
 * Picks elements in_off .. in_off+ELEMS_PER_LINE-1 out of a two-line window.
 * Offset bits are spread evenly over SHIFT_STAGES registered steps.
 * Latency is exactly SHIFT_STAGES cycles, one window per cycle.
 */
`timescale 1ns/10ps
`default_nettype none

module line_shifter #(
	parameter int ELEMS_PER_LINE = align_pkg::elems_per_line,
	parameter int ELEM_WIDTH     = align_pkg::elem_width,
	parameter int SHIFT_STAGES   = align_pkg::shift_stages
) (
	input  wire                                    clk,
	input  wire                                    rst_n,
	input  wire                                    in_valid,
	input  wire  [$clog2(ELEMS_PER_LINE)-1:0]      in_off,
	input  wire                                    in_last,
	input  wire  [2*ELEMS_PER_LINE*ELEM_WIDTH-1:0] in_data,
	output logic                                   out_valid,
	output logic                                   out_last,
	output logic [ELEMS_PER_LINE*ELEM_WIDTH-1:0]   out_data
);

	localparam int LINE_W = ELEMS_PER_LINE * ELEM_WIDTH;
	localparam int WIN_W  = 2 * LINE_W;
	localparam int OFF_W  = $clog2(ELEMS_PER_LINE);
	// Offset bits handled per stage
	localparam int BPS    = (OFF_W + SHIFT_STAGES - 1) / SHIFT_STAGES;

	logic [WIN_W-1:0]        win_q   [SHIFT_STAGES];
	logic [OFF_W-1:0]        off_q   [SHIFT_STAGES];
	logic [SHIFT_STAGES-1:0] valid_q;
	logic [SHIFT_STAGES-1:0] last_q;

	// One step applies only the offset bits owned by this stage
	function automatic logic [WIN_W-1:0] shift_step(
		input logic [WIN_W-1:0] win,
		input logic [OFF_W-1:0] off,
		input int               stage
	);
		logic [WIN_W-1:0] w;
		w = win;
		for (int b = 0; b < OFF_W; b++) begin
			if ((b / BPS) == stage && off[b])
				w = w >> ((1 << b) * ELEM_WIDTH);
		end
		return w;
	endfunction

	////////////////////////////////////////////////////////////////////
	// Control pipe
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q <= '0;
			last_q  <= '0;
		end else begin
			valid_q[0] <= in_valid;
			// Last only counts together with valid
			last_q[0]  <= in_valid && in_last;
			for (int s = 1; s < SHIFT_STAGES; s++) begin
				valid_q[s] <= valid_q[s-1];
				last_q[s]  <= last_q[s-1];
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// Data pipe with the offset travelling beside its window
	always_ff @(posedge clk) begin
		win_q[0] <= shift_step(in_data, in_off, 0);
		off_q[0] <= in_off;
		for (int s = 1; s < SHIFT_STAGES; s++) begin
			win_q[s] <= shift_step(win_q[s-1], off_q[s-1], s);
			off_q[s] <= off_q[s-1];
		end
	end

	// Lower line of the fully shifted window
	assign out_data  = win_q[SHIFT_STAGES-1][LINE_W-1:0];
	assign out_valid = valid_q[SHIFT_STAGES-1];
	assign out_last  = last_q[SHIFT_STAGES-1];

	// Offset must be known and inside a line
	a_off_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> (!$isunknown(in_off) && in_off < ELEMS_PER_LINE));

endmodule

`default_nettype wire

/* hdl/bus_aligner.sv */
/*
 * Two-line staging window in front of the element shifter.
 * Output has no back-pressure and lines leave as soon as they are ready.
 * A stream's offset must stay constant over all its lines.
 */
`timescale 1ns/10ps
`default_nettype none

module bus_aligner #(
	parameter int ELEMS_PER_LINE = align_pkg::elems_per_line,
	parameter int ELEM_WIDTH     = align_pkg::elem_width,
	parameter int SHIFT_STAGES   = align_pkg::shift_stages
) (
	input  wire                                  clk,
	input  wire                                  rst_n,
	input  wire  [ELEMS_PER_LINE*ELEM_WIDTH-1:0] data_in,
	input  wire                                  data_in_valid,
	input  wire                                  data_in_last,
	input  wire  [$clog2(ELEMS_PER_LINE)-1:0]    data_in_off,
	input  wire  [$clog2(ELEMS_PER_LINE):0]      data_in_word_count,
	input  wire  align_pkg::sideband_t           data_in_sideband,
	input  wire                                  stream_last,
	output logic [ELEMS_PER_LINE*ELEM_WIDTH-1:0] data_out,
	output logic                                 data_out_valid,
	output logic                                 data_out_last,
	output align_pkg::sideband_t                 data_out_sideband
);

	localparam int LINE_W = ELEMS_PER_LINE * ELEM_WIDTH;
	localparam int OFF_W  = $clog2(ELEMS_PER_LINE);

	// Stage 1 holds the next line
	logic [LINE_W-1:0]    s1_data;
	logic                 s1_valid;
	logic                 s1_last;
	logic [OFF_W-1:0]     s1_off;
	logic [OFF_W:0]       s1_count;
	align_pkg::sideband_t s1_sideband;
	// Stream end delayed to line up with stage 2
	logic                 end_d1;

	// Stage 2 holds the current line
	logic [LINE_W-1:0]    s2_data;
	logic                 s2_valid;
	logic                 s2_last;
	logic [OFF_W-1:0]     s2_off;
	align_pkg::sideband_t s2_sideband;

	logic flush;
	logic window_valid;
	logic window_last;

	////////////////////////////////////////////////////////////////////
	// Staging window
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			end_d1   <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= data_in_valid;
			end_d1   <= stream_last;
			if (!s2_valid)
				s2_valid <= s1_valid;
			else if (s1_valid)
				// Final line dropped when its elements fit the current output
				s2_valid <= s2_last || !s1_last || (s1_count > s2_off);
			else if (flush)
				s2_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		s1_data     <= data_in;
		s1_last     <= data_in_last;
		s1_off      <= data_in_off;
		s1_count    <= data_in_word_count;
		s1_sideband <= data_in_sideband;
		// Stage 2 holds until a follower arrives
		if (!s2_valid || s1_valid) begin
			s2_data     <= s1_data;
			s2_last     <= s1_last;
			s2_off      <= s1_off;
			s2_sideband <= s1_sideband;
		end
	end

	// Held final line with no follower
	assign flush        = s2_valid && s2_last && end_d1;
	assign window_valid = s2_valid && (s1_valid || flush);
	// Also last when the follower is final and adds nothing
	assign window_last  = s2_last ||
		(s1_valid && s1_last && (s1_count <= s2_off));

	////////////////////////////////////////////////////////////////////
	// Shifter and sideband delay share one depth
	line_shifter #(
		.ELEMS_PER_LINE (ELEMS_PER_LINE),
		.ELEM_WIDTH     (ELEM_WIDTH),
		.SHIFT_STAGES   (SHIFT_STAGES)
	) u_shifter (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (window_valid),
		.in_off    (s2_off),
		.in_last   (window_last),
		.in_data   ({s1_data, s2_data}),
		.out_valid (data_out_valid),
		.out_last  (data_out_last),
		.out_data  (data_out)
	);

	delay_line #(
		.payload_t (align_pkg::sideband_t),
		.DEPTH     (SHIFT_STAGES)
	) u_sideband_delay (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_payload  (s2_sideband),
		.in_valid    (window_valid),
		.out_payload (data_out_sideband),
		.out_valid   ()
	);

endmodule

`default_nettype wire

/* hdl/stream_framer.sv */
/*
 * Four-phase descriptor handshake, one stream at a time.
 * desc_total must be nonzero. Lines are taken on every valid cycle.
 */
`timescale 1ns/10ps
`default_nettype none

module stream_framer #(
	parameter int ELEMS_PER_LINE = align_pkg::elems_per_line,
	parameter int ELEM_WIDTH     = align_pkg::elem_width
) (
	input  wire                                  clk,
	input  wire                                  rst_n,
	input  wire                                  desc_req,
	input  wire  [$clog2(ELEMS_PER_LINE)-1:0]    desc_off,
	input  wire  [align_pkg::total_width-1:0]    desc_total,
	input  wire  align_pkg::sideband_t           desc_sideband,
	input  wire  [ELEMS_PER_LINE*ELEM_WIDTH-1:0] line_data,
	input  wire                                  line_valid,
	output logic                                 desc_ack,
	output logic [ELEMS_PER_LINE*ELEM_WIDTH-1:0] data_in,
	output logic                                 data_in_valid,
	output logic                                 data_in_last,
	output logic [$clog2(ELEMS_PER_LINE)-1:0]    data_in_off,
	output logic [$clog2(ELEMS_PER_LINE):0]      data_in_word_count,
	output align_pkg::sideband_t                 data_in_sideband,
	output logic                                 stream_last
);

	localparam int CNT_W = $clog2(ELEMS_PER_LINE) + 1;
	// Offset plus total as counted from the first line's start
	localparam int REM_W = align_pkg::total_width + 1;

	logic                              active;
	logic [$clog2(ELEMS_PER_LINE)-1:0] off_q;
	align_pkg::sideband_t              sideband_q;
	logic [REM_W-1:0]                  remain_q;
	logic                              take;
	logic                              last_now;

	assign take     = line_valid && active;
	// Last line once the remainder fits
	assign last_now = remain_q <= REM_W'(ELEMS_PER_LINE);

	////////////////////////////////////////////////////////////////////
	// Handshake and stream state
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			desc_ack <= 1'b0;
			active   <= 1'b0;
		end else begin
			// Ack only when the previous stream is fully in
			if (!desc_ack && desc_req && !active) begin
				desc_ack <= 1'b1;
				active   <= 1'b1;
			end else if (desc_ack && !desc_req) begin
				desc_ack <= 1'b0;
			end
			if (take && last_now)
				active <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!desc_ack && desc_req && !active) begin
			off_q      <= desc_off;
			sideband_q <= desc_sideband;
			remain_q   <= REM_W'(desc_total) + REM_W'(desc_off);
		end else if (take && !last_now) begin
			remain_q <= remain_q - REM_W'(ELEMS_PER_LINE);
		end
	end

	////////////////////////////////////////////////////////////////////
	// Tagged line register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			data_in_valid <= 1'b0;
			stream_last   <= 1'b0;
		end else begin
			data_in_valid <= take;
			// Pulse one cycle after the final line
			stream_last   <= data_in_valid && data_in_last;
		end
	end

	always_ff @(posedge clk) begin
		data_in            <= line_data;
		data_in_last       <= last_now;
		data_in_off        <= off_q;
		data_in_word_count <= last_now ? remain_q[CNT_W-1:0] : CNT_W'(ELEMS_PER_LINE);
		data_in_sideband   <= sideband_q;
	end

	a_line_needs_stream: assert property (@(posedge clk) disable iff (!rst_n)
		line_valid |-> active);

	// Source keeps req up until it sees ack
	a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
		(desc_req && !desc_ack) |=> (desc_req || desc_ack));

endmodule

`default_nettype wire

/* hdl/aligner_top.sv */
/*
 * Stream realigner: framer feeding the two-line aligner.
 * Output has no ready and must be consumed as it appears.
 */
`timescale 1ns/10ps
`default_nettype none

module aligner_top #(
	parameter int ELEMS_PER_LINE = align_pkg::elems_per_line,
	parameter int ELEM_WIDTH     = align_pkg::elem_width,
	parameter int SHIFT_STAGES   = align_pkg::shift_stages
) (
	input  wire                                  clk,
	input  wire                                  rst_n,
	input  wire                                  desc_req,
	input  wire  [$clog2(ELEMS_PER_LINE)-1:0]    desc_off,
	input  wire  [align_pkg::total_width-1:0]    desc_total,
	input  wire  align_pkg::sideband_t           desc_sideband,
	input  wire  [ELEMS_PER_LINE*ELEM_WIDTH-1:0] line_data,
	input  wire                                  line_valid,
	output logic                                 desc_ack,
	output logic [ELEMS_PER_LINE*ELEM_WIDTH-1:0] out_data,
	output logic                                 out_valid,
	output logic                                 out_last,
	output align_pkg::sideband_t                 out_sideband
);

	localparam int LINE_W = ELEMS_PER_LINE * ELEM_WIDTH;
	localparam int OFF_W  = $clog2(ELEMS_PER_LINE);

	// Tagged lines, framer to aligner
	logic [LINE_W-1:0]    data_in;
	logic                 data_in_valid;
	logic                 data_in_last;
	logic [OFF_W-1:0]     data_in_off;
	logic [OFF_W:0]       data_in_word_count;
	align_pkg::sideband_t data_in_sideband;
	logic                 stream_last;

	stream_framer #(
		.ELEMS_PER_LINE (ELEMS_PER_LINE),
		.ELEM_WIDTH     (ELEM_WIDTH)
	) u_framer (
		.clk                (clk),
		.rst_n              (rst_n),
		.desc_req           (desc_req),
		.desc_off           (desc_off),
		.desc_total         (desc_total),
		.desc_sideband      (desc_sideband),
		.line_data          (line_data),
		.line_valid         (line_valid),
		.desc_ack           (desc_ack),
		.data_in            (data_in),
		.data_in_valid      (data_in_valid),
		.data_in_last       (data_in_last),
		.data_in_off        (data_in_off),
		.data_in_word_count (data_in_word_count),
		.data_in_sideband   (data_in_sideband),
		.stream_last        (stream_last)
	);

	bus_aligner #(
		.ELEMS_PER_LINE (ELEMS_PER_LINE),
		.ELEM_WIDTH     (ELEM_WIDTH),
		.SHIFT_STAGES   (SHIFT_STAGES)
	) u_aligner (
		.clk                (clk),
		.rst_n              (rst_n),
		.data_in            (data_in),
		.data_in_valid      (data_in_valid),
		.data_in_last       (data_in_last),
		.data_in_off        (data_in_off),
		.data_in_word_count (data_in_word_count),
		.data_in_sideband   (data_in_sideband),
		.stream_last        (stream_last),
		.data_out           (out_data),
		.data_out_valid     (out_valid),
		.data_out_last      (out_last),
		.data_out_sideband  (out_sideband)
	);

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
/*
 * Free-running clock and synchronous active-low reset for the testbench.
 * Reset rises a short delay after its last rising edge.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 4,
	parameter int RELEASE_DLY  = 2
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Held low for RESET_CYCLES rising edges
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#RELEASE_DLY;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* testbench/tb_aligner.sv */
/*
 * Testbench for aligner_top, run from the project root.
 * Streams come from testbench/align_patterns.txt, one descriptor at a time.
 * Stops at the first mismatch. Elements past the count in a last line are masked.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_aligner;

	localparam int LINE_W       = align_pkg::line_width;
	localparam int ELEMS        = align_pkg::elems_per_line;
	localparam int EW           = align_pkg::elem_width;
	localparam int PERIOD_NS    = 40;
	localparam int RESET_CYCLES = 4;
	localparam int DRIVE_DLY    = 2;
	localparam int NUM_STREAMS  = 6;
	// Six headers, 14 input lines, 12 expected lines
	localparam int MEM_WORDS    = 32;
	localparam int MAX_GAP      = 3;

	logic                              clk;
	logic                              rst_n;
	logic                              desc_req;
	logic [align_pkg::off_width-1:0]   desc_off;
	logic [align_pkg::total_width-1:0] desc_total;
	align_pkg::sideband_t              desc_sideband;
	logic [LINE_W-1:0]                 line_data;
	logic                              line_valid;
	logic                              desc_ack;
	logic [LINE_W-1:0]                 out_data;
	logic                              out_valid;
	logic                              out_last;
	align_pkg::sideband_t              out_sideband;

	logic [LINE_W-1:0] pat_mem [MEM_WORDS];
	int                hdr_idx [NUM_STREAMS];

	// Expected output lines in arrival order
	logic [LINE_W-1:0]    exp_data_q  [$];
	int                   exp_count_q [$];
	logic                 exp_last_q  [$];
	align_pkg::sideband_t exp_sb_q    [$];

	int lines_expected = 0;
	int lines_seen     = 0;
	int total_lines    = 0;
	bit patterns_ready = 1'b0;

	tb_clock_gen #(
		.PERIOD_NS    (PERIOD_NS),
		.RESET_CYCLES (RESET_CYCLES),
		.RELEASE_DLY  (DRIVE_DLY)
	) u_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	aligner_top #(
		.ELEMS_PER_LINE (align_pkg::elems_per_line),
		.ELEM_WIDTH     (align_pkg::elem_width),
		.SHIFT_STAGES   (align_pkg::shift_stages)
	) UUT (
		.clk           (clk),
		.rst_n         (rst_n),
		.desc_req      (desc_req),
		.desc_off      (desc_off),
		.desc_total    (desc_total),
		.desc_sideband (desc_sideband),
		.line_data     (line_data),
		.line_valid    (line_valid),
		.desc_ack      (desc_ack),
		.out_data      (out_data),
		.out_valid     (out_valid),
		.out_last      (out_last),
		.out_sideband  (out_sideband)
	);

	////////////////////////////////////////////////////////////////////
	// Reporting and checks
	task automatic report_failure(input string what);
		$display("%s", what);
		$display("Verification failed");
		$fatal(1, "Run stopped at first failure");
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("** Error at %0d ns: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic compare_sideband(input align_pkg::sideband_t got,
		input align_pkg::sideband_t exp);
		if (got !== exp)
			report_failure($sformatf("** Error at %0d ns: out_sideband got %h expected %h",
				$time, got, exp));
	endtask

	// Only the first count elements are defined
	task automatic compare_line(input logic [LINE_W-1:0] got,
		input logic [LINE_W-1:0] exp, input int count);
		logic [EW-1:0] g;
		logic [EW-1:0] e;
		for (int k = 0; k < ELEMS; k++) begin
			g = got[k*EW +: EW];
			e = exp[k*EW +: EW];
			if (k < count && g !== e)
				report_failure($sformatf(
					"** Error at %0d ns: out_data element %0d got %h expected %h",
					$time, k, g, e));
		end
	endtask

	// Lines needed to hold n elements
	function automatic int line_count(input int n);
		return (n + ELEMS - 1) / ELEMS;
	endfunction

	////////////////////////////////////////////////////////////////////
	// Pattern file and expected queue
	task automatic load_patterns();
		logic [31:0] hdr;
		int          ptr;
		int          off;
		int          total;
		int          last_cnt;
		int          n_in;
		int          n_out;
		$readmemh("testbench/align_patterns.txt", pat_mem);
		ptr = 0;
		for (int s = 0; s < NUM_STREAMS; s++) begin
			hdr = pat_mem[ptr][31:0];
			if ($isunknown(hdr))
				report_failure("Pattern file is missing or shorter than six streams");
			off      = hdr[31:28];
			total    = hdr[27:16];
			last_cnt = hdr[11:8];
			n_in     = hdr[7:4];
			n_out    = hdr[3:0];
			// Counts must follow from offset and total
			if (n_in != line_count(off + total) || n_out != line_count(total) ||
				last_cnt != total - ELEMS * (n_out - 1))
				report_failure($sformatf("Pattern header of stream %0d has wrong counts", s));
			hdr_idx[s] = ptr;
			for (int i = 0; i < n_out; i++) begin
				exp_data_q.push_back(pat_mem[ptr + 1 + n_in + i]);
				exp_count_q.push_back((i == n_out - 1) ? last_cnt : ELEMS);
				exp_last_q.push_back(i == n_out - 1);
				exp_sb_q.push_back(align_pkg::sideband_t'(hdr[15:12]));
			end
			total_lines += n_in + n_out;
			ptr += 1 + n_in + n_out;
		end
		lines_expected = exp_data_q.size();
	endtask

	////////////////////////////////////////////////////////////////////
	// Stimulus changes a short delay after the rising edge
	task automatic send_descriptor(input int off, input int total,
		input align_pkg::sideband_t sb);
		desc_off      = off[align_pkg::off_width-1:0];
		desc_total    = total[align_pkg::total_width-1:0];
		desc_sideband = sb;
		desc_req      = 1'b1;
		// Hold req until ack rises
		do begin
			@(posedge clk);
			#DRIVE_DLY;
		end while (desc_ack !== 1'b1);
		desc_req = 1'b0;
		// Drop req and wait for ack to fall
		do begin
			@(posedge clk);
			#DRIVE_DLY;
		end while (desc_ack !== 1'b0);
	endtask

	// Random idle gap before one valid cycle
	task automatic send_line(input logic [LINE_W-1:0] data);
		int gap;
		gap = $urandom_range(MAX_GAP, 0);
		repeat (gap) begin
			@(posedge clk);
			#DRIVE_DLY;
			compare_bit("desc_ack", desc_ack, 1'b0);
		end
		line_data  = data;
		line_valid = 1'b1;
		@(posedge clk);
		#DRIVE_DLY;
		line_valid = 1'b0;
		compare_bit("desc_ack", desc_ack, 1'b0);
	endtask

	initial begin : driver
		logic [31:0] hdr;
		int          n_in;
		desc_req      = 1'b0;
		desc_off      = '0;
		desc_total    = '0;
		desc_sideband = '0;
		line_data     = '0;
		line_valid    = 1'b0;
		void'($urandom(19));
		load_patterns();
		patterns_ready = 1'b1;

		// Still inside reset here
		repeat (RESET_CYCLES - 1) @(negedge clk);
		compare_bit("desc_ack", desc_ack, 1'b0);
		compare_bit("out_valid", out_valid, 1'b0);
		compare_bit("out_last", out_last, 1'b0);

		// Idle after reset before any descriptor
		wait (rst_n === 1'b1);
		repeat (6) begin
			@(posedge clk);
			#DRIVE_DLY;
			compare_bit("desc_ack", desc_ack, 1'b0);
			compare_bit("out_valid", out_valid, 1'b0);
			compare_bit("out_last", out_last, 1'b0);
		end

		// Streams back to back
		for (int s = 0; s < NUM_STREAMS; s++) begin
			hdr  = pat_mem[hdr_idx[s]][31:0];
			n_in = hdr[7:4];
			send_descriptor(hdr[31:28], hdr[27:16], align_pkg::sideband_t'(hdr[15:12]));
			for (int i = 0; i < n_in; i++)
				send_line(pat_mem[hdr_idx[s] + 1 + i]);
		end

		while (lines_seen < lines_expected)
			@(posedge clk);
		// Any extra line would hit the monitor here
		repeat (2 * align_pkg::shift_stages + 4) @(posedge clk);
		if (lines_seen == lines_expected && exp_data_q.size() == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			report_failure("Number of output lines differs from the patterns");
		end
	end

	////////////////////////////////////////////////////////////////////
	// Output monitor samples mid-cycle
	always @(negedge clk) begin
		if (rst_n === 1'b1 && out_valid !== 1'b0) begin
			if (out_valid !== 1'b1)
				report_failure("out_valid is unknown after reset");
			else if (exp_data_q.size() == 0)
				report_failure("Output line appeared with no expected line left");
			else begin
				compare_line(out_data, exp_data_q.pop_front(), exp_count_q.pop_front());
				compare_sideband(out_sideband, exp_sb_q.pop_front());
				compare_bit("out_last", out_last, exp_last_q.pop_front());
				lines_seen++;
			end
		end
	end

	// Watchdog allows MAX_GAP idle cycles before every line
	initial begin : watchdog
		int limit_ns;
		wait (patterns_ready);
		limit_ns = (2 * (MAX_GAP + 1) * total_lines + 20 * NUM_STREAMS + 40) * PERIOD_NS;
		#(limit_ns);
		report_failure($sformatf("Timeout after %0d ns with %0d of %0d output lines seen",
			limit_ns, lines_seen, lines_expected));
	end

endmodule

`default_nettype wire

/* filelist.f */
hdl/align_pkg.sv
hdl/delay_line.sv
hdl/line_shifter.sv
hdl/bus_aligner.sv
hdl/stream_framer.sv
hdl/aligner_top.sv
testbench/tb_clock_gen.sv
testbench/tb_aligner.sv

/* testbench/align_patterns.txt */
// Each stream is one header word then its input lines then its expected output lines
// Header o_ttt_s_c_i_n holds offset total sideband last line count inputs outputs
// Element 0 of a line is the rightmost group and masked elements are written as 0000
// Stream 1 at offset 0
0_014_5_4_3_3
1007_1006_1005_1004_1003_1002_1001_1000
100f_100e_100d_100c_100b_100a_1009_1008
1017_1016_1015_1014_1013_1012_1011_1010
1007_1006_1005_1004_1003_1002_1001_1000
100f_100e_100d_100c_100b_100a_1009_1008
0000_0000_0000_0000_1013_1012_1011_1010
// Stream 2 at offset 3 across line boundaries
3_015_9_5_3_3
2007_2006_2005_2004_2003_2002_2001_2000
200f_200e_200d_200c_200b_200a_2009_2008
2017_2016_2015_2014_2013_2012_2011_2010
200a_2009_2008_2007_2006_2005_2004_2003
2012_2011_2010_200f_200e_200d_200c_200b
0000_0000_0000_2017_2016_2015_2014_2013
// Stream 3 where the last input line folds into the previous output
6_00d_2_5_3_2
3007_3006_3005_3004_3003_3002_3001_3000
300f_300e_300d_300c_300b_300a_3009_3008
3017_3016_3015_3014_3013_3012_3011_3010
300d_300c_300b_300a_3009_3008_3007_3006
0000_0000_0000_3012_3011_3010_300f_300e
// Stream 4 at offset 1
1_00f_a_7_2_2
4007_4006_4005_4004_4003_4002_4001_4000
400f_400e_400d_400c_400b_400a_4009_4008
4008_4007_4006_4005_4004_4003_4002_4001
0000_400f_400e_400d_400c_400b_400a_4009
// Stream 5 at offset 7 with a folded last line
7_003_3_3_2_1
5007_5006_5005_5004_5003_5002_5001_5000
500f_500e_500d_500c_500b_500a_5009_5008
0000_0000_0000_0000_0000_5009_5008_5007
// Stream 6 with a single short line
2_005_c_5_1_1
6007_6006_6005_6004_6003_6002_6001_6000
0000_0000_0000_6006_6005_6004_6003_6002
